/* mcu_macros.svh */
// MCU register map and link codes
`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// register bus addresses
`define MCU_ADDR_ID        16'h0000
`define MCU_ADDR_SCRATCH   16'h0001
`define MCU_ADDR_SPWORD    16'h0002
`define MCU_ADDR_TESTPATT  16'h0003
`define MCU_ADDR_TESTEN    16'h0004
`define MCU_ADDR_BADIDLE_A 16'h0010
`define MCU_ADDR_BADIDLE_B 16'h0011

`define MCU_ID_VALUE       16'h1234 // fixed board identifier

// incoming word layout
`define MCU_TRIG_BIT       7
`define MCU_IDLE_MASK      8'b11001100 // bits 3:2 carry the idle phase
`define MCU_IDLE0          8'b01000000
`define MCU_IDLE1          8'b01000100
`define MCU_IDLE2          8'b01001000
`define MCU_IDLE3          8'b01001100

// outgoing 4-bit codes
`define MCU_K_IDLE0        4'b0111 // idle rotation, one zero walks right
`define MCU_K_IDLE1        4'b1011
`define MCU_K_IDLE2        4'b1101
`define MCU_K_IDLE3        4'b1110
`define MCU_K_NCOIN        4'b1001 // reject, no partner found
`define MCU_K_PCOIN        4'b0011 // accept, prompt coincidence
`define MCU_K_SPECL        4'b1100 // leads a special word

`endif

/* mcuPkg.sv */
// MCU shared types
package mcuPkg;

   // one word received from a front-end cable
   // bit 7 marks a trigger, otherwise the word is an idle
   typedef logic [7:0] linkWordT;

   // one code sent back to the front-end board
   typedef logic [3:0] txCodeT;

   // register bus
   typedef logic [15:0] regAddrT;
   typedef logic [15:0] regDataT;

   // bad-idle counter and the idle sequence count carried by idle words
   typedef logic [15:0] idleCountT;

   // transmitter states
   typedef enum logic [3:0] {
      IDLE0, // idle rotation
      IDLE1,
      IDLE2,
      IDLE3,
      NCOIN, // reject code
      PCOIN, // accept code
      SPECL, // special word lead-in
      SPEC1, // nibble 15:12
      SPEC2, // nibble 11:8
      SPEC3, // nibble 7:4
      SPEC4  // nibble 3:0
   } txStateT;

endpackage

/* controlRegisters.sv */
// Control register block
`include "mcu_macros.svh"

module controlRegisters (
   input  logic              clk,
   input  logic              rst,
   input  logic              busReq,     // four-phase request from host
   input  logic              busWrite,   // 1 = write, 0 = read
   input  mcuPkg::regAddrT   busAddr,
   input  mcuPkg::regDataT   busWrData,
   output logic              busAck,
   output mcuPkg::regDataT   busRdData,  // valid while busAck is high
   input  mcuPkg::idleCountT badIdleA,
   input  mcuPkg::idleCountT badIdleB,
   output mcuPkg::regDataT   specialWord,
   output logic              sendSpecial, // one cycle per special write
   output mcuPkg::txCodeT    testPattern,
   output logic              testEnableA,
   output logic              testEnableB
);

   logic            reqPrev;  // busReq one cycle ago
   logic            start;    // rising edge of busReq, no handshake open
   mcuPkg::regDataT scratch;
   mcuPkg::regDataT readMux;

   // new access only on a fresh request and with the previous ack gone
   assign start = busReq && !reqPrev && !busAck;

   // read data selection
   always_comb begin
      case (busAddr)
         `MCU_ADDR_ID:        readMux = `MCU_ID_VALUE;
         `MCU_ADDR_SCRATCH:   readMux = scratch;
         `MCU_ADDR_SPWORD:    readMux = specialWord;
         `MCU_ADDR_TESTPATT:  readMux = {12'd0, testPattern};
         `MCU_ADDR_TESTEN:    readMux = {14'd0, testEnableB, testEnableA};
         `MCU_ADDR_BADIDLE_A: readMux = badIdleA;
         `MCU_ADDR_BADIDLE_B: readMux = badIdleB;
         default:             readMux = '0; // unmapped
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         reqPrev     <= 1'b0;
         busAck      <= 1'b0;
         sendSpecial <= 1'b0;
         scratch     <= '0;
         specialWord <= '0;
         testPattern <= '0;
         testEnableA <= 1'b0;
         testEnableB <= 1'b0;
      end else begin
         reqPrev <= busReq;
         if (start) begin
            busAck <= 1'b1;             // ack on the edge after req rises
         end else if (!busReq) begin
            busAck <= 1'b0;             // drop once the host lets go
         end
         // pulse rises together with busAck
         sendSpecial <= start && busWrite && (busAddr == `MCU_ADDR_SPWORD);
         if (start && busWrite) begin
            case (busAddr)
               `MCU_ADDR_SCRATCH:  scratch     <= busWrData;
               `MCU_ADDR_SPWORD:   specialWord <= busWrData;
               `MCU_ADDR_TESTPATT: testPattern <= busWrData[3:0];
               `MCU_ADDR_TESTEN: begin
                  testEnableA <= busWrData[0];
                  testEnableB <= busWrData[1];
               end
               default: ;                // read-only and unmapped ignore writes
            endcase
         end
      end
   end

   // read data held from the accepting edge until the next access
   always_ff @(posedge clk) begin
      if (start) begin
         busRdData <= readMux;
      end
   end

endmodule

/* linkReceiver.sv */
// Cable link receiver
`include "mcu_macros.svh"

module linkReceiver (
   input  logic              clk,
   input  logic              rst,
   input  mcuPkg::linkWordT  cableIn,
   output logic              single,       // one-cycle trigger pulse
   output mcuPkg::idleCountT badIdleCount  // wraps, never saturates
);

   mcuPkg::linkWordT  inWord;     // word sampled from the cable
   mcuPkg::linkWordT  prevWord;   // the word before it
   logic              inValid;    // inWord was sampled out of reset
   logic              prevValid;  // prevWord as well
   logic              inIdle;
   logic              prevIdle;
   logic [1:0]        inPhase;
   logic [1:0]        prevPhase;
   mcuPkg::idleCountT assembled;  // nibbles collected from the current set
   mcuPkg::idleCountT fullCount;  // set completed by a phase-3 word
   mcuPkg::idleCountT lastCount;  // count of the previous completed set
   logic              countValid; // a set has completed since reset
   logic              idleBad;    // bad word or broken phase order
   logic              countBad;   // count did not step by one

   // returns {valid idle, phase}
   function automatic logic [2:0] decodeIdle(input mcuPkg::linkWordT w);
      logic [2:0] res;
      res = 3'b000;
      if (!w[`MCU_TRIG_BIT]) begin
         case (w & `MCU_IDLE_MASK)
            `MCU_IDLE0: res = 3'b100;
            `MCU_IDLE1: res = 3'b101;
            `MCU_IDLE2: res = 3'b110;
            `MCU_IDLE3: res = 3'b111;
            default:    res = 3'b000;
         endcase
      end
      return res;
   endfunction

   assign {inIdle, inPhase}     = decodeIdle(inWord);
   assign {prevIdle, prevPhase} = decodeIdle(prevWord);

   // phase 3 holds count bits 15:12
   assign fullCount = {inWord[5:4], inWord[1:0], assembled[11:0]};

   always_comb begin
      idleBad  = 1'b0;
      countBad = 1'b0;
      if (inValid && !inWord[`MCU_TRIG_BIT]) begin
         if (!inIdle) begin
            idleBad = 1'b1;                     // neither trigger nor idle
         end else if (prevValid) begin
            if (inPhase == 2'd0) begin
               // after a trigger a new set may start anywhere
               idleBad = !prevWord[`MCU_TRIG_BIT] &&
                         !(prevIdle && prevPhase == 2'd3);
            end else begin
               idleBad = !(prevIdle && prevPhase == inPhase - 2'd1);
            end
         end
         if (inIdle && inPhase == 2'd3 && countValid) begin
            countBad = (fullCount != mcuPkg::idleCountT'(lastCount + 16'd1));
         end
      end
   end

   // input pipeline and nibble assembly
   always_ff @(posedge clk) begin
      inWord   <= cableIn;
      prevWord <= inWord;
      if (inIdle) begin
         assembled[{inPhase, 2'b00} +: 4] <= {inWord[5:4], inWord[1:0]};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         inValid      <= 1'b0;
         prevValid    <= 1'b0;
         single       <= 1'b0;
         badIdleCount <= '0;
         lastCount    <= '0;
         countValid   <= 1'b0;
      end else begin
         inValid      <= 1'b1;
         prevValid    <= inValid;
         single       <= inWord[`MCU_TRIG_BIT];  // one cycle after sampling
         badIdleCount <= badIdleCount + mcuPkg::idleCountT'(idleBad)
                                      + mcuPkg::idleCountT'(countBad);
         if (inValid && inIdle && inPhase == 2'd3) begin
            lastCount  <= fullCount;
            countValid <= 1'b1;
         end
      end
   end

endmodule

/* coincidenceUnit.sv */
// A/B coincidence unit
module coincidenceUnit (
   input  logic clk,
   input  logic rst,
   input  logic singleA,
   input  logic singleB,
   output logic acceptA,  // partner seen on B within one cycle
   output logic rejectA,  // no partner on B
   output logic acceptB,
   output logic rejectB
);

   // single history, bit 0 newest
   // the middle stage is the one being decided
   // bit 0 of the other side is one cycle later, bit 2 one cycle earlier
   logic [2:0] histA;
   logic [2:0] histB;
   logic       partnerA;  // B has a single near the middle stage of A
   logic       partnerB;

   assign partnerA = |histB;
   assign partnerB = |histA;

   always_ff @(posedge clk) begin
      if (rst) begin
         histA   <= '0;
         histB   <= '0;
         acceptA <= 1'b0;
         rejectA <= 1'b0;
         acceptB <= 1'b0;
         rejectB <= 1'b0;
      end else begin
         histA <= {histA[1:0], singleA};
         histB <= {histB[1:0], singleB};
         // each side answers every single exactly once
         // pulses last one cycle
         acceptA <= histA[1] && partnerA;
         rejectA <= histA[1] && !partnerA;
         acceptB <= histB[1] && partnerB;
         rejectB <= histB[1] && !partnerB;
      end
   end

endmodule

/* linkTransmitter.sv */
// Cable link transmitter
`include "mcu_macros.svh"

module linkTransmitter (
   input  logic            clk,
   input  logic            rst,
   input  logic            accept,
   input  logic            reject,
   input  mcuPkg::regDataT specialWord,
   input  logic            sendSpecial,  // starts the special sequence
   input  mcuPkg::txCodeT  testPattern,
   input  logic            testEnable,   // overrides the output only
   output mcuPkg::txCodeT  cableOut
);

   mcuPkg::txStateT state;
   mcuPkg::txStateT nextState;
   mcuPkg::txCodeT  stateCode;  // code belonging to the current state
   logic            canBranch;  // state may leave for coincidence or special

   // special nibbles in flight are never interrupted
   assign canBranch = !(state inside {mcuPkg::SPECL, mcuPkg::SPEC1,
                                      mcuPkg::SPEC2, mcuPkg::SPEC3});

   always_comb begin
      case (state)
         mcuPkg::IDLE0: nextState = mcuPkg::IDLE1;
         mcuPkg::IDLE1: nextState = mcuPkg::IDLE2;
         mcuPkg::IDLE2: nextState = mcuPkg::IDLE3;
         mcuPkg::SPECL: nextState = mcuPkg::SPEC1;
         mcuPkg::SPEC1: nextState = mcuPkg::SPEC2;
         mcuPkg::SPEC2: nextState = mcuPkg::SPEC3;
         mcuPkg::SPEC3: nextState = mcuPkg::SPEC4;
         default:       nextState = mcuPkg::IDLE0; // IDLE3, NCOIN, PCOIN, SPEC4
      endcase
      if (canBranch) begin
         if (accept) begin
            nextState = mcuPkg::PCOIN;  // accept wins over reject
         end else if (reject) begin
            nextState = mcuPkg::NCOIN;
         end
         if (sendSpecial) begin
            nextState = mcuPkg::SPECL;  // highest priority
         end
      end
   end

   always_comb begin
      case (state)
         mcuPkg::IDLE0: stateCode = `MCU_K_IDLE0;
         mcuPkg::IDLE1: stateCode = `MCU_K_IDLE1;
         mcuPkg::IDLE2: stateCode = `MCU_K_IDLE2;
         mcuPkg::IDLE3: stateCode = `MCU_K_IDLE3;
         mcuPkg::NCOIN: stateCode = `MCU_K_NCOIN;
         mcuPkg::PCOIN: stateCode = `MCU_K_PCOIN;
         mcuPkg::SPECL: stateCode = `MCU_K_SPECL;
         mcuPkg::SPEC1: stateCode = specialWord[15:12]; // msb nibble first
         mcuPkg::SPEC2: stateCode = specialWord[11:8];
         mcuPkg::SPEC3: stateCode = specialWord[7:4];
         mcuPkg::SPEC4: stateCode = specialWord[3:0];
         default:       stateCode = `MCU_K_IDLE0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= mcuPkg::IDLE0;
         cableOut <= '0;
      end else begin
         state <= nextState;
         // output lags the state by one register
         if (testEnable) begin
            cableOut <= testPattern;  // fixed pattern for link tests
         end else begin
            cableOut <= stateCode;
         end
      end
   end

endmodule

/* mcuLogic.sv */
// Master Coincidence Unit top
module mcuLogic (
   input  logic             clk,
   input  logic             rst,
   input  logic             busReq,
   input  logic             busWrite,
   input  mcuPkg::regAddrT  busAddr,
   input  mcuPkg::regDataT  busWrData,
   output logic             busAck,
   output mcuPkg::regDataT  busRdData,
   input  mcuPkg::linkWordT cableAIn,   // words from front-end board A
   input  mcuPkg::linkWordT cableBIn,
   output mcuPkg::txCodeT   cableAOut,  // codes back to board A
   output mcuPkg::txCodeT   cableBOut
);

   logic              singleA;
   logic              singleB;
   mcuPkg::idleCountT badIdleA;
   mcuPkg::idleCountT badIdleB;
   logic              acceptA;
   logic              rejectA;
   logic              acceptB;
   logic              rejectB;
   mcuPkg::regDataT   specialWord;
   logic              sendSpecial;
   mcuPkg::txCodeT    testPattern;
   logic              testEnableA;
   logic              testEnableB;

   controlRegisters regs (
      .clk(clk), .rst(rst),
      .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr),
      .busWrData(busWrData), .busAck(busAck), .busRdData(busRdData),
      .badIdleA(badIdleA), .badIdleB(badIdleB),
      .specialWord(specialWord), .sendSpecial(sendSpecial),
      .testPattern(testPattern),
      .testEnableA(testEnableA), .testEnableB(testEnableB)
   );

   // receivers run side by side
   linkReceiver rxA (
      .clk(clk), .rst(rst), .cableIn(cableAIn),
      .single(singleA), .badIdleCount(badIdleA)
   );

   linkReceiver rxB (
      .clk(clk), .rst(rst), .cableIn(cableBIn),
      .single(singleB), .badIdleCount(badIdleB)
   );

   coincidenceUnit coinc (
      .clk(clk), .rst(rst),
      .singleA(singleA), .singleB(singleB),
      .acceptA(acceptA), .rejectA(rejectA),
      .acceptB(acceptB), .rejectB(rejectB)
   );

   // special word goes out on both cables at once
   linkTransmitter txA (
      .clk(clk), .rst(rst), .accept(acceptA), .reject(rejectA),
      .specialWord(specialWord), .sendSpecial(sendSpecial),
      .testPattern(testPattern), .testEnable(testEnableA),
      .cableOut(cableAOut)
   );

   linkTransmitter txB (
      .clk(clk), .rst(rst), .accept(acceptB), .reject(rejectB),
      .specialWord(specialWord), .sendSpecial(sendSpecial),
      .testPattern(testPattern), .testEnable(testEnableB),
      .cableOut(cableBOut)
   );

endmodule

/* tbClock.sv */
// Testbench clock and reset
module tbClock (
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk); // reset held for 8 cycles
      #1;
      rst = 1'b0;
   end

endmodule

/* mcuLogicTb.sv */
// MCU directed testbench
`include "mcu_macros.svh"

module mcuLogicTb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HistLen    = 2048;
   localparam int TestCycles = 450; // rough length of all tests
   localparam int BusLimit   = 20;  // cycles allowed per handshake phase

   logic              clk;
   logic              rst;
   logic              busReq;
   logic              busWr;
   mcuPkg::regAddrT   busAddr;
   mcuPkg::regDataT   busWrData;
   logic              busAck;
   mcuPkg::regDataT   busRdData;
   mcuPkg::linkWordT  cableAIn;
   mcuPkg::linkWordT  cableBIn;
   mcuPkg::txCodeT    cableAOut;
   mcuPkg::txCodeT    cableBOut;

   int                errors = 0;
   int                testsPassed = 0;
   int                testsFailed = 0;
   int                cycle = 0;              // rising edges seen so far
   logic [31:0]       rngState = 32'd62878;
   mcuPkg::txCodeT    histA [HistLen];        // cableAOut after each edge
   mcuPkg::txCodeT    histB [HistLen];
   logic [9:0]        queueA [$];             // {kind, word} with kind 0 idle, 1 literal, 2 skip
   logic [9:0]        queueB [$];
   mcuPkg::idleCountT genCount [2];           // idle stream generators
   logic [1:0]        genPhase [2];
   mcuPkg::linkWordT  mPrev [2];              // reference model of the bad-idle rules
   logic              mHasPrev [2];
   mcuPkg::idleCountT mAssembled [2];
   mcuPkg::idleCountT mLast [2];
   logic              mCountValid [2];
   mcuPkg::idleCountT expBad [2];

   tbClock clkGen (.clk(clk), .rst(rst));

   mcuLogic mcuLogic_inst (
      .clk(clk), .rst(rst),
      .busReq(busReq), .busWrite(busWr), .busAddr(busAddr), .busWrData(busWrData),
      .busAck(busAck), .busRdData(busRdData),
      .cableAIn(cableAIn), .cableBIn(cableBIn),
      .cableAOut(cableAOut), .cableBOut(cableBOut)
   );

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   // idle word of phase ph carrying count bits 4ph+3..4ph
   function automatic mcuPkg::linkWordT idleWord(input mcuPkg::idleCountT cnt,
                                                 input logic [1:0] ph);
      logic [3:0] nib;
      nib = cnt[{ph, 2'b00} +: 4];
      return {2'b01, nib[3:2], ph, nib[1:0]};
   endfunction

   function automatic mcuPkg::linkWordT nextStreamWord(input int side);
      mcuPkg::linkWordT w;
      w = idleWord(genCount[side], genPhase[side]);
      if (genPhase[side] == 2'd3) begin
         genCount[side] = genCount[side] + 16'd1; // next count once the set is done
      end
      genPhase[side] = genPhase[side] + 2'd1;
      return w;
   endfunction

   // applies the receiver rules to one word sent on a cable
   function automatic void modelWord(input int side, input mcuPkg::linkWordT w);
      logic              isIdle;
      logic              prevIdle;
      logic [1:0]        ph;
      logic [1:0]        prevPh;
      logic              bad;
      mcuPkg::idleCountT acc;
      isIdle   = !w[`MCU_TRIG_BIT] && (w[6] == 1'b1);
      ph       = w[3:2];
      prevIdle = !mPrev[side][`MCU_TRIG_BIT] && (mPrev[side][6] == 1'b1);
      prevPh   = mPrev[side][3:2];
      bad      = 1'b0;
      if (!w[`MCU_TRIG_BIT]) begin
         if (!isIdle) begin
            bad = 1'b1;
         end else if (mHasPrev[side]) begin
            if (ph == 2'd0) begin
               bad = !mPrev[side][`MCU_TRIG_BIT] && !(prevIdle && prevPh == 2'd3);
            end else begin
               bad = !(prevIdle && prevPh == ph - 2'd1);
            end
         end
         if (bad) expBad[side] = expBad[side] + 16'd1;
         if (isIdle) begin
            acc = mAssembled[side];
            acc[{ph, 2'b00} +: 4] = {w[5:4], w[1:0]};
            mAssembled[side] = acc;
            if (ph == 2'd3) begin
               if (mCountValid[side] && acc != mLast[side] + 16'd1) begin
                  expBad[side] = expBad[side] + 16'd1; // count did not step by one
               end
               mLast[side]       = acc;
               mCountValid[side] = 1'b1;
            end
         end
      end
      mPrev[side]    = w;
      mHasPrev[side] = 1'b1;
   endfunction

   function automatic mcuPkg::linkWordT streamWord(input int side);
      logic [9:0]       ent;
      mcuPkg::linkWordT w;
      ent = 10'd0;
      if (side == 0 && queueA.size() > 0) ent = queueA.pop_front();
      if (side == 1 && queueB.size() > 0) ent = queueB.pop_front();
      if (ent[9:8] == 2'd1) begin
         w = ent[7:0];
      end else begin
         if (ent[9:8] == 2'd2) genCount[side] = genCount[side] + 16'd1; // skipped count
         w = nextStreamWord(side);
      end
      modelWord(side, w);
      return w;
   endfunction

   // records outputs and drives both cables every cycle
   initial begin : streamDriver
      cableAIn = '0;
      cableBIn = '0;
      forever begin
         @(posedge clk);
         #2;
         cycle = cycle + 1;
         if (cycle < HistLen) begin
            histA[cycle] = cableAOut;
            histB[cycle] = cableBOut;
         end
         if (!rst) begin
            cableAIn = streamWord(0);
            cableBIn = streamWord(1);
         end
      end
   end

   initial begin : watchdog
      #((TestCycles * 2 + 100) * 20);
      $display("watchdog expired, the tests did not finish in time");
      $display("TESTBENCH FAILED");
      $finish;
   end

   function automatic mcuPkg::txCodeT codeAt(input int side, input int idx);
      return (side == 0) ? histA[idx] : histB[idx];
   endfunction

   function automatic logic isIdleCode(input mcuPkg::txCodeT c);
      return c == `MCU_K_IDLE0 || c == `MCU_K_IDLE1 || c == `MCU_K_IDLE2 ||
             c == `MCU_K_IDLE3;
   endfunction

   function automatic mcuPkg::txCodeT nextIdleCode(input mcuPkg::txCodeT c);
      case (c)
         `MCU_K_IDLE0: return `MCU_K_IDLE1;
         `MCU_K_IDLE1: return `MCU_K_IDLE2;
         `MCU_K_IDLE2: return `MCU_K_IDLE3;
         default:      return `MCU_K_IDLE0;
      endcase
   endfunction

   task automatic checkData(input string name, input mcuPkg::regDataT exp,
                            input mcuPkg::regDataT act);
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkCount(input string name, input mcuPkg::idleCountT exp,
                             input mcuPkg::idleCountT act);
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic checkCode(input string name, input mcuPkg::txCodeT exp,
                            input mcuPkg::txCodeT act);
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic failNote(input string what);
      errors++;
      $display("%s", what);
   endtask

   task automatic reportTest(input string name, input int errStart);
      if (errors == errStart) begin
         testsPassed++;
         $display("test %s: ok", name);
      end else begin
         testsFailed++;
         $display("test %s: %0d errors", name, errors - errStart);
      end
   endtask

   task automatic waitAck(input logic level, output logic ok);
      int n;
      n = 0;
      while (busAck !== level && n < BusLimit) begin
         @(posedge clk);
         #2;
         n++;
      end
      ok = (busAck === level);
   endtask

   task automatic busRead(input mcuPkg::regAddrT addr, output mcuPkg::regDataT data);
      logic ok1;
      logic ok2;
      logic ok3;
      waitAck(1'b0, ok1);
      @(posedge clk);
      #2;
      busReq = 1'b1;
      busWr  = 1'b0;
      busAddr = addr;
      @(posedge clk);
      #2;
      waitAck(1'b1, ok2);
      data   = busRdData;    // valid while busAck is high
      busReq = 1'b0;
      @(posedge clk);
      #2;
      waitAck(1'b0, ok3);
      if (!(ok1 && ok2 && ok3)) failNote($sformatf("bus read of %h timed out", addr));
   endtask

   task automatic busWrite(input mcuPkg::regAddrT addr, input mcuPkg::regDataT data);
      logic ok1;
      logic ok2;
      logic ok3;
      waitAck(1'b0, ok1);
      @(posedge clk);
      #2;
      busReq    = 1'b1;
      busWr     = 1'b1;
      busAddr   = addr;
      busWrData = data;
      @(posedge clk);
      #2;
      waitAck(1'b1, ok2);
      busReq = 1'b0;
      @(posedge clk);
      #2;
      waitAck(1'b0, ok3);
      if (!(ok1 && ok2 && ok3)) failNote($sformatf("bus write to %h timed out", addr));
   endtask

   task automatic markCycle(output int c);
      @(posedge clk);
      #3;
      c = cycle;
   endtask

   // returns the edge that samples the first queued word
   task automatic alignPush(output int sampleEdge);
      @(posedge clk);
      #1;
      sampleEdge = cycle + 2;
   endtask

   task automatic waitCycle(input int n);
      do begin
         @(posedge clk);
         #3;
      end while (cycle < n);
   endtask

   task automatic checkIdleRun(input string name, input int side, input int from,
                               input int n);
      mcuPkg::txCodeT prev;
      prev = codeAt(side, from);
      if (!isIdleCode(prev)) failNote($sformatf("%s: code %b is not an idle code", name, prev));
      for (int i = 1; i < n; i++) begin
         checkCode(name, nextIdleCode(prev), codeAt(side, from + i));
         prev = codeAt(side, from + i);
      end
   endtask

   // first non-idle code 4 to 10 cycles after the trigger is sampled
   task automatic findCoin(input string name, input int side, input int s,
                           input mcuPkg::txCodeT exp);
      int found;
      found = 0;
      for (int i = s + 4; i <= s + 10; i++) begin
         if (found == 0 && !isIdleCode(codeAt(side, i))) found = i;
      end
      if (found == 0) failNote($sformatf("%s: no coincidence code within 10 cycles", name));
      else checkCode(name, exp, codeAt(side, found));
   endtask

   task automatic coinCase(input string name, input logic withB, input int delay,
                           input mcuPkg::txCodeT expCode);
      int s;
      alignPush(s);
      queueA.push_back({2'd1, 8'h80});
      for (int i = 0; i < delay; i++) queueB.push_back(10'd0);
      if (withB) queueB.push_back({2'd1, 8'h80});
      waitCycle(s + delay + 12);
      findCoin({name, " A"}, 0, s, expCode);
      if (withB) begin
         findCoin({name, " B"}, 1, s + delay, expCode);
      end else begin
         for (int i = s + 1; i <= s + 11; i++) begin
            if (!isIdleCode(codeAt(1, i))) failNote({name, ": cable B sent a non-idle code"});
         end
      end
   endtask

   task automatic testRegisters();
      int              e;
      logic            ok;
      mcuPkg::regDataT d;
      mcuPkg::regDataT v;
      e = errors;
      busRead(`MCU_ADDR_ID, d);
      checkData("ID register", `MCU_ID_VALUE, d);
      v = mcuPkg::regDataT'(xorshift());
      busWrite(`MCU_ADDR_SCRATCH, v);
      busRead(`MCU_ADDR_SCRATCH, d);
      checkData("scratch readback", v, d);
      busRead(16'h0100, d);
      checkData("unmapped read", 16'h0000, d);
      // host keeps busReq high, so busAck must never fall
      @(posedge clk);
      #2;
      busReq  = 1'b1;
      busWr   = 1'b0;
      busAddr = `MCU_ADDR_ID;
      @(posedge clk);
      #2;
      waitAck(1'b1, ok);
      if (!ok) failNote("busAck never rose for the held request");
      waitAck(1'b0, ok);
      if (ok) failNote("busAck fell while busReq was still held");
      else $display("held request: handshake timeout after %0d cycles, as intended", BusLimit);
      busReq = 1'b0;
      waitAck(1'b0, ok);
      if (!ok) failNote("busAck stuck high after busReq was released");
      reportTest("registers", e);
   endtask

   task automatic testIdleCodes();
      int e;
      int c;
      e = errors;
      markCycle(c);
      waitCycle(c + 9);
      checkIdleRun("idle rotation A", 0, c + 1, 8);
      checkIdleRun("idle rotation B", 1, c + 1, 8);
      reportTest("idle codes", e);
   endtask

   task automatic testIdleCheck();
      int              e;
      int              s;
      mcuPkg::regDataT a0;
      mcuPkg::regDataT d;
      e = errors;
      busRead(`MCU_ADDR_BADIDLE_A, a0);
      checkCount("bad-idle A clean", 16'd0, a0);
      alignPush(s);
      queueB.push_back({2'd1, 8'h3F});          // neither trigger nor idle
      repeat (5) queueB.push_back(10'd0);
      queueB.push_back({2'd1, 8'h48});          // phase 2 out of order
      repeat (6) queueB.push_back(10'd0);
      queueB.push_back({2'd2, 8'h00});          // count jumps by one
      waitCycle(s + 40);
      busRead(`MCU_ADDR_BADIDLE_B, d);
      checkCount("bad-idle B", expBad[1], d);
      busRead(`MCU_ADDR_BADIDLE_A, d);
      checkCount("bad-idle A unchanged", expBad[0], d);
      reportTest("idle checking", e);
   endtask

   task automatic testCoincidence();
      int e;
      e = errors;
      coinCase("lone trigger", 1'b0, 0, `MCU_K_NCOIN);
      coinCase("same cycle", 1'b1, 0, `MCU_K_PCOIN);
      coinCase("one apart", 1'b1, 1, `MCU_K_PCOIN);
      coinCase("two apart", 1'b1, 2, `MCU_K_NCOIN);
      reportTest("coincidence", e);
   endtask

   task automatic testSpecial();
      int              e;
      int              c;
      int              f;
      mcuPkg::regDataT w;
      e = errors;
      w = mcuPkg::regDataT'(xorshift());
      markCycle(c);
      busWrite(`MCU_ADDR_SPWORD, w);
      waitCycle(c + 25);
      for (int side = 0; side < 2; side++) begin
         f = 0;
         for (int i = c; i <= c + 20; i++) begin
            if (f == 0 && codeAt(side, i) == `MCU_K_SPECL) f = i;
         end
         if (f == 0) begin
            failNote($sformatf("special lead code missing on cable %0d", side));
         end else begin
            checkCode("special nibble 15:12", w[15:12], codeAt(side, f + 1));
            checkCode("special nibble 11:8", w[11:8], codeAt(side, f + 2));
            checkCode("special nibble 7:4", w[7:4], codeAt(side, f + 3));
            checkCode("special nibble 3:0", w[3:0], codeAt(side, f + 4));
         end
      end
      reportTest("special word", e);
   endtask

   task automatic testPatternOut();
      int             e;
      int             c;
      mcuPkg::txCodeT pat;
      e = errors;
      pat = mcuPkg::txCodeT'(xorshift());
      busWrite(`MCU_ADDR_TESTPATT, {12'd0, pat});
      busWrite(`MCU_ADDR_TESTEN, 16'h0001);
      markCycle(c);
      waitCycle(c + 10);
      for (int i = c + 1; i <= c + 9; i++) checkCode("test pattern A", pat, codeAt(0, i));
      checkIdleRun("idle B during test", 1, c + 1, 9);
      busWrite(`MCU_ADDR_TESTEN, 16'h0000);
      markCycle(c);
      waitCycle(c + 10);
      checkIdleRun("idle A after test", 0, c + 1, 9);
      reportTest("test pattern", e);
   endtask

   initial begin : mainSeq
      logic [31:0] r;
      busReq    = 1'b0;
      busWr     = 1'b0;
      busAddr   = '0;
      busWrData = '0;
      for (int i = 0; i < 2; i++) begin
         r = xorshift();
         genCount[i]    = r[15:0];    // random idle counter start
         genPhase[i]    = 2'd0;
         mPrev[i]       = '0;
         mHasPrev[i]    = 1'b0;
         mAssembled[i]  = '0;
         mLast[i]       = '0;
         mCountValid[i] = 1'b0;
         expBad[i]      = '0;
      end
      wait (rst === 1'b0);
      testRegisters();
      testIdleCodes();
      testIdleCheck();
      testCoincidence();
      testSpecial();
      testPatternOut();
      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               testsPassed, testsFailed, errors);
      if (errors == 0 && testsFailed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* mcuLogic.f */
+incdir+.
mcuPkg.sv
controlRegisters.sv
linkReceiver.sv
coincidenceUnit.sv
linkTransmitter.sv
mcuLogic.sv
tbClock.sv
mcuLogicTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the MCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module mcuLogicTb -f mcuLogic.f -o simv

output="$(./obj_dir/simv)"
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
   exit 0
else
   exit 1
fi
